// ==== verilog.f ====
src/video_pkg.sv
src/palette_ram.sv
src/video_dac.sv
src/video_out.sv
src/video_color_top.sv
bench/video_color_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module video_color_tb -o video_color_sim
status=0
./obj_dir/video_color_sim > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "Done: errors found" sim.log; then
	exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Done: no errors" sim.log; then
	exit 1
fi
exit 0

// ==== bench/video_color_tb.sv ====
module video_color_tb;
	timeunit 1ns;
	timeprecision 1ps;

	////////////////////////////////////////
	// Run parameters
	////////////////////////////////////////

	localparam int clk_period = 8;
	localparam int reset_cycles = 10;
	// Reset, ladder load and sweep, blanking, random fill and stream, collision, flushes
	localparam int test_cycles = reset_cycles + 2 * 16 + 32 + 256 + 1024 + 2
		+ 5 * video_pkg::pipe_latency;

	logic                  clk;
	logic                  rst_n;
	video_pkg::pixel_t     pix;
	logic                  pal_we;
	logic [7:0]            pal_addr;
	video_pkg::rgb4_t      pal_data;
	video_pkg::rgb8_t      rgb;
	video_pkg::video_ctl_t sync;

	int          errors;
	int          checks;
	logic [31:0] lcg_state;

	// Expected palette as updated by each modelled CPU write
	video_pkg::rgb4_t      exp_pal [256];
	// Expected pin values with one entry per pixel still in flight
	video_pkg::rgb8_t      exp_rgb_q [$];
	video_pkg::video_ctl_t exp_ctl_q [$];

	video_color_top video_color_top_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.pix      (pix),
		.pal_we   (pal_we),
		.pal_addr (pal_addr),
		.pal_data (pal_data),
		.rgb      (rgb),
		.sync     (sync)
	);

	initial clk = 1'b0;
	always #(clk_period / 2) clk = ~clk;

	////////////////////////////////////////
	// Helpers and reference model
	////////////////////////////////////////

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Ladder as a divider with the set conductances over the 8128 uS total
	function automatic logic [7:0] ladder_level(input logic [3:0] code);
		int unsigned g [4];
		int unsigned sum;
		g = '{455, 1000, 2128, 4545};
		sum = 0;
		for (int i = 0; i < 4; i++) begin
			if (code[i]) begin
				sum += g[i];
			end
		end
		return 8'((sum * 255) / 8128);
	endfunction

	function automatic video_pkg::pixel_t make_pixel(input logic [7:0] index, input logic hs,
		input logic vs, input logic bl);
		video_pkg::pixel_t p;
		p.index = index;
		p.ctl.hsync = hs;
		p.ctl.vsync = vs;
		p.ctl.blank = bl;
		return p;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH at %0t ns: %s actual 0x%0h expected 0x%0h",
				$time, name, actual, expected);
		end
	endtask

	// Oldest pixel in flight against the pins
	task automatic compare_output();
		video_pkg::rgb8_t      want_rgb;
		video_pkg::video_ctl_t want_ctl;
		want_rgb = exp_rgb_q.pop_front();
		want_ctl = exp_ctl_q.pop_front();
		check_value("rgb.r", rgb.r, want_rgb.r);
		check_value("rgb.g", rgb.g, want_rgb.g);
		check_value("rgb.b", rgb.b, want_rgb.b);
		check_value("sync.hsync", sync.hsync, want_ctl.hsync);
		check_value("sync.vsync", sync.vsync, want_ctl.vsync);
		check_value("sync.blank", sync.blank, want_ctl.blank);
	endtask

	// One clock of stimulus starting 1 ns after a rising edge
	task automatic drive_cycle(input video_pkg::pixel_t p, input logic we,
		input logic [7:0] addr, input video_pkg::rgb4_t data);
		video_pkg::rgb8_t want_rgb;
		video_pkg::rgb4_t entry;
		// Read sees the entry before a same-edge write
		entry = exp_pal[p.index];
		if (p.ctl.blank) begin
			want_rgb = '0;
		end else begin
			want_rgb.r = ladder_level(entry.r);
			want_rgb.g = ladder_level(entry.g);
			want_rgb.b = ladder_level(entry.b);
		end
		pix = p;
		pal_we = we;
		pal_addr = addr;
		pal_data = data;
		exp_rgb_q.push_back(want_rgb);
		exp_ctl_q.push_back(p.ctl);
		if (we) begin
			exp_pal[addr] = data;
		end
		@(posedge clk);
		#1;
		// Pixel sampled pipe_latency edges ago is now on the pins
		if (exp_rgb_q.size() == video_pkg::pipe_latency) begin
			compare_output();
		end
	endtask

	task automatic flush_pipe();
		for (int i = 0; i < video_pkg::pipe_latency; i++) begin
			drive_cycle(make_pixel(8'd0, 1'b0, 1'b0, 1'b1), 1'b0, 8'd0, '0);
		end
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic check_reset();
		rst_n = 1'b0;
		for (int i = 0; i < reset_cycles; i++) begin
			@(posedge clk);
			#1;
			check_value("rgb in reset", rgb, 0);
			check_value("sync in reset", sync, 0);
		end
		rst_n = 1'b1;
		// Cleared stages still reach the pins for the first cycles out of reset
		for (int i = 0; i < video_pkg::pipe_latency - 1; i++) begin
			exp_rgb_q.push_back('0);
			exp_ctl_q.push_back('0);
		end
	endtask

	task automatic sweep_ladder();
		video_pkg::rgb4_t c;
		for (int i = 0; i < 16; i++) begin
			c.r = 4'(i);
			c.g = 4'(i);
			c.b = 4'(i);
			drive_cycle(make_pixel(8'd0, 1'b0, 1'b0, 1'b1), 1'b1, 8'(i), c);
		end
		// Every code through all three guns including the end points
		for (int i = 0; i < 16; i++) begin
			drive_cycle(make_pixel(8'(i), 1'b0, 1'b0, 1'b0), 1'b0, 8'd0, '0);
		end
		flush_pipe();
	endtask

	task automatic toggle_blanking();
		logic [4:0] k;
		for (int i = 0; i < 32; i++) begin
			k = 5'(i);
			// Entries 1 to 15 are never black, so a zero pin means blanking
			drive_cycle(make_pixel(8'((i % 15) + 1), k[1], k[3], k[0] ^ k[2]), 1'b0, 8'd0, '0);
		end
		flush_pipe();
	endtask

	task automatic stream_random();
		logic [31:0] w;
		for (int a = 0; a < 256; a++) begin
			w = lcg_next();
			drive_cycle(make_pixel(8'd0, 1'b0, 1'b0, 1'b1), 1'b1, 8'(a), w[27:16]);
		end
		for (int i = 0; i < 1024; i++) begin
			w = lcg_next();
			drive_cycle(make_pixel(w[23:16], w[28], w[29], w[30]), 1'b0, 8'd0, '0);
		end
		flush_pipe();
	endtask

	task automatic collide_write_read();
		logic [7:0]       addr;
		video_pkg::rgb4_t new_entry;
		addr = 8'h5a;
		new_entry = ~exp_pal[addr];
		// Write and read on one edge leave the pixel with the old color
		drive_cycle(make_pixel(addr, 1'b0, 1'b0, 1'b0), 1'b1, addr, new_entry);
		// Next read of the address shows the new entry
		drive_cycle(make_pixel(addr, 1'b0, 1'b0, 1'b0), 1'b0, 8'd0, '0);
		flush_pipe();
	endtask

	////////////////////////////////////////
	// Sequence and watchdog
	////////////////////////////////////////

	initial begin
		errors = 0;
		checks = 0;
		lcg_state = 32'h5992;
		rst_n = 1'b0;
		pix = make_pixel(8'd0, 1'b0, 1'b0, 1'b1);
		pal_we = 1'b0;
		pal_addr = 8'd0;
		pal_data = '0;
		check_reset();
		sweep_ladder();
		toggle_blanking();
		stream_random();
		collide_write_read();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// Twice the expected run length
	initial begin
		#(2 * test_cycles * clk_period);
		$display("Watchdog expired, the tests did not finish in time");
		$display("Done: errors found");
		$finish;
	end

endmodule

// ==== src/video_color_top.sv ====
module video_color_top (
	input  logic                              clk,
	input  logic                              rst_n,
	input  video_pkg::pixel_t                 pix,
	input  logic                              pal_we,
	input  logic [video_pkg::pix_index_w-1:0] pal_addr,
	input  video_pkg::rgb4_t                  pal_data,
	output video_pkg::rgb8_t                  rgb,
	output video_pkg::video_ctl_t             sync
);

	// Palette lookup to DAC
	video_pkg::rgb4_t      pal_color;
	video_pkg::video_ctl_t pal_ctl;

	// DAC to output stage
	video_pkg::rgb8_t      dac_out_level;
	video_pkg::video_ctl_t dac_ctl;

	// Index to color codes, one cycle
	palette_ram palette_ram_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.pix      (pix),
		.pal_we   (pal_we),
		.pal_addr (pal_addr),
		.pal_data (pal_data),
		.color    (pal_color),
		.ctl      (pal_ctl)
	);

	// Color codes to intensities, one cycle
	video_dac video_dac_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.color  (pal_color),
		.ctl_in (pal_ctl),
		.level  (dac_out_level),
		.ctl    (dac_ctl)
	);

	// Blanking and pin register, one cycle
	video_out video_out_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.level  (dac_out_level),
		.ctl_in (dac_ctl),
		.rgb    (rgb),
		.sync   (sync)
	);

endmodule

// ==== src/video_out.sv ====
module video_out (
	input  logic                  clk,
	input  logic                  rst_n,
	input  video_pkg::rgb8_t      level,
	input  video_pkg::video_ctl_t ctl_in,
	output video_pkg::rgb8_t      rgb,
	output video_pkg::video_ctl_t sync
);

	////////////////////////////////////////
	// Blanking
	////////////////////////////////////////

	// Color as the monitor should see it
	video_pkg::rgb8_t rgb_next;

	// Outside the active area the guns must be off
	// Otherwise the retrace shows up as bright diagonal lines
	// Black level also gives the monitor its reference for clamping
	always_comb begin
		if (ctl_in.blank) begin
			rgb_next = '0;
		end else begin
			rgb_next = level;
		end
	end

	////////////////////////////////////////
	// Output register
	////////////////////////////////////////

	// Final pixel register driving the connector pins
	// Out of reset the screen is black
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rgb <= '0;
		end else begin
			rgb <= rgb_next;
		end
	end

	// Sync and blank leave on the same edge as the color
	// Keeps the picture from shifting against hsync
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sync <= '0;
		end else begin
			sync <= ctl_in;
		end
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	// A blank seen at the input gives black at the pins on the next cycle
	a_blank_black : assert property (
		@(posedge clk) disable iff (!rst_n)
		ctl_in.blank |=> (rgb == '0)
	) else $error("video_out: color present one cycle after blank");

endmodule

// ==== src/video_dac.sv ====
module video_dac (
	input  logic                  clk,
	input  logic                  rst_n,
	input  video_pkg::rgb4_t      color,
	input  video_pkg::video_ctl_t ctl_in,
	output video_pkg::rgb8_t      level,
	output video_pkg::video_ctl_t ctl
);

	////////////////////////////////////////
	// Ladder table
	////////////////////////////////////////

	// Each code bit drives its own resistor into the summing node
	// Set bits tie their resistor to the high rail, cleared bits to ground
	// The node is then a divider between the set and the cleared conductances
	// Vout / Vmax = g_set / (g_set + g_clr) = g_set / g_total
	// Monitor input impedance is left out, so the divider is unloaded
	logic [video_pkg::dac_out_w-1:0] level_tbl [2 ** video_pkg::dac_in_w];

	// Constant entries fixed at elaboration
	for (genvar i = 0; i < 2 ** video_pkg::dac_in_w; i++) begin : g_tbl
		// Code value for this entry
		localparam logic [video_pkg::dac_in_w-1:0] code = i;
		assign level_tbl[i] = video_pkg::dac_level(code);
	end

	////////////////////////////////////////
	// Per channel lookup
	////////////////////////////////////////

	// All three guns share the one ladder table
	// The board uses the same resistor values on every gun
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			level <= '0;
		end else begin
			level.r <= level_tbl[color.r];
			level.g <= level_tbl[color.g];
			level.b <= level_tbl[color.b];
		end
	end

	// Control delayed by the same cycle as the colors
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ctl <= '0;
		end else begin
			ctl <= ctl_in;
		end
	end

endmodule

// ==== src/palette_ram.sv ====
module palette_ram (
	input  logic                              clk,
	input  logic                              rst_n,
	input  video_pkg::pixel_t                 pix,
	input  logic                              pal_we,
	input  logic [video_pkg::pix_index_w-1:0] pal_addr,
	input  video_pkg::rgb4_t                  pal_data,
	output video_pkg::rgb4_t                  color,
	output video_pkg::video_ctl_t             ctl
);

	////////////////////////////////////////
	// Palette storage
	////////////////////////////////////////

	// One rgb4 entry per index
	// The CPU loads the contents after power up
	video_pkg::rgb4_t pal_mem [video_pkg::pal_depth];

	// CPU side write port
	// Single cycle strobe with no handshake back to the CPU
	always_ff @(posedge clk) begin
		if (pal_we) begin
			pal_mem[pal_addr] <= pal_data;
		end
	end

	////////////////////////////////////////
	// Pixel side read
	////////////////////////////////////////

	// Registered lookup with one cycle from index to color
	// Nonblocking read of the array gives the entry as it was before this edge
	// So a same-edge CPU write to the same address is seen one pixel later
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			color <= '0;
		end else begin
			color <= pal_mem[pix.index];
		end
	end

	// Control levels ride along with the lookup
	// Same single register so sync stays on the same pixel
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ctl <= '0;
		end else begin
			ctl <= pix.ctl;
		end
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	// Visible pixels must carry a clean index
	// An X here would smear through the DAC onto the screen
	// During blank the index is a don't care and may float
	a_index_known : assert property (
		@(posedge clk) disable iff (!rst_n)
		!pix.ctl.blank |-> !$isunknown(pix.index)
	) else $error("palette_ram: unknown pixel index outside blank");

	// A CPU write must also carry a clean address
	a_waddr_known : assert property (
		@(posedge clk) disable iff (!rst_n)
		pal_we |-> !$isunknown(pal_addr)
	) else $error("palette_ram: unknown write address");

endmodule

// ==== src/video_pkg.sv ====
package video_pkg;

	////////////////////////////////////////
	// Widths and sizes
	////////////////////////////////////////

	// Palette index carried by each pixel
	localparam int pix_index_w = 8;
	// One palette entry per index value
	localparam int pal_depth = 256;
	// Color code per channel into the DAC
	localparam int dac_in_w = 4;
	// Intensity per channel out of the DAC
	localparam int dac_out_w = 8;
	// Pixel in to pixel out, counting the sampling edge
	localparam int pipe_latency = 3;

	////////////////////////////////////////
	// Resistor ladder
	////////////////////////////////////////

	// Conductances in microsiemens, bit 0 first
	// 2200, 1000, 470 and 220 ohm resistors
	localparam int unsigned dac_g [0:3] = '{455, 1000, 2128, 4545};
	// All four resistors in parallel
	localparam int unsigned dac_g_total = dac_g[0] + dac_g[1] + dac_g[2] + dac_g[3];

	////////////////////////////////////////
	// Pixel and color types
	////////////////////////////////////////

	// Monitor control levels, all active high
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic blank;
	} video_ctl_t;

	// One pixel of the incoming stream
	typedef struct packed {
		logic [pix_index_w-1:0] index;
		video_ctl_t             ctl;
	} pixel_t;

	// Palette entry, one 4-bit code per gun
	typedef struct packed {
		logic [dac_in_w-1:0] r;
		logic [dac_in_w-1:0] g;
		logic [dac_in_w-1:0] b;
	} rgb4_t;

	// DAC output, one 8-bit intensity per gun
	typedef struct packed {
		logic [dac_out_w-1:0] r;
		logic [dac_out_w-1:0] g;
		logic [dac_out_w-1:0] b;
	} rgb8_t;

	// Code to intensity through the ladder
	// Sum of set conductances over the total, scaled to full range and rounded down
	function automatic logic [dac_out_w-1:0] dac_level(input logic [dac_in_w-1:0] code);
		int unsigned g_on;
		int unsigned scaled;
		g_on = 0;
		for (int i = 0; i < dac_in_w; i++) begin
			if (code[i]) begin
				g_on += dac_g[i];
			end
		end
		// Worst case 8128 * 255 stays well inside 32 bits
		scaled = (g_on * ((2 ** dac_out_w) - 1)) / dac_g_total;
		return scaled[dac_out_w-1:0];
	endfunction

endpackage
